// File: hw/host_cfg_pkg.sv
// Host domain address map, region encoding and bus widths
package host_cfg_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;

  // L2 scratchpad window, aliased beyond the physical size
  localparam logic [ADDR_WIDTH-1:0] L2_BASE   = 32'h0000_0000;
  localparam logic [ADDR_WIDTH-1:0] L2_WINDOW = 32'h0001_0000;

  localparam logic [ADDR_WIDTH-1:0] MBOX_BASE = 32'h0001_0000;
  localparam logic [ADDR_WIDTH-1:0] CNT_BASE  = 32'h0002_0000;

  // Mailbox and counter regions are both this large
  localparam logic [ADDR_WIDTH-1:0] REGION_SIZE = 32'h0000_0010;

  // Mailbox byte offsets
  localparam logic [3:0] DOORBELL_SET   = 4'h0;
  localparam logic [3:0] DOORBELL_CLR   = 4'h4;
  localparam logic [3:0] COMPLETION_SET = 4'h8;
  localparam logic [3:0] COMPLETION_CLR = 4'hc;

  // Counter byte offsets, offset 12 reads as zero
  localparam logic [3:0] READ_CNT  = 4'h0;
  localparam logic [3:0] WRITE_CNT = 4'h4;
  localparam logic [3:0] ERROR_CNT = 4'h8;

  typedef enum logic [1:0] {
    REGION_L2,
    REGION_MBOX,
    REGION_CNT,
    REGION_NONE
  } region_e;

endpackage

// File: hw/host_bus_pkg.sv
// Wishbone port structs and the internal target request struct
package host_bus_pkg;

  // Word offset wide enough for the whole L2 window
  localparam int unsigned WOFF_WIDTH = $clog2(host_cfg_pkg::L2_WINDOW) - 2;
  localparam int unsigned SEL_WIDTH  = host_cfg_pkg::DATA_WIDTH / 8;

  // Master to slave, 71 bits
  typedef struct packed {
    logic [host_cfg_pkg::ADDR_WIDTH-1:0] adr;
    logic [host_cfg_pkg::DATA_WIDTH-1:0] dat;
    logic [SEL_WIDTH-1:0]                sel;
    logic                                we;
    logic                                cyc;
    logic                                stb;
  } wb_req_t;

  // Slave to master, 34 bits
  typedef struct packed {
    logic [host_cfg_pkg::DATA_WIDTH-1:0] dat;
    logic                                ack;
    logic                                err;
  } wb_rsp_t;

  // Single cycle strobe from the bus FSM to one target
  typedef struct packed {
    logic                                valid;
    logic                                we;
    logic [WOFF_WIDTH-1:0]               woff;
    logic [host_cfg_pkg::DATA_WIDTH-1:0] dat;
    logic [SEL_WIDTH-1:0]                sel;
  } tgt_req_t;

endpackage

// File: hw/host_bus_fsm.sv
// Wishbone classic slave FSM with region decode and target strobes
`timescale 1ns/1ps

module host_bus_fsm
  import host_cfg_pkg::*;
  import host_bus_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  wb_req_t               wb_req_i,
  output wb_rsp_t               wb_rsp_o,
  output tgt_req_t              l2_req_o,
  output tgt_req_t              mbox_req_o,
  output tgt_req_t              cnt_req_o,
  input  logic [DATA_WIDTH-1:0] l2_rdata_i,
  input  logic [DATA_WIDTH-1:0] mbox_rdata_i,
  input  logic [DATA_WIDTH-1:0] cnt_rdata_i,
  output logic                  l2_rd_o,
  output logic                  l2_wr_o,
  output logic                  bus_err_o
);

  typedef enum logic [1:0] {IDLE, ACCESS, RESP} state_e;

  state_e                  state_q, state_d;
  logic                    req_start;
  logic [ADDR_WIDTH-1:0]   l2_offs, mbox_offs, cnt_offs, offs_d;
  region_e                 region_d, region_q;
  logic [WOFF_WIDTH-1:0]   woff_q;
  logic                    we_q;
  logic [DATA_WIDTH-1:0]   dat_q;
  logic [SEL_WIDTH-1:0]    sel_q;
  tgt_req_t                acc_req;
  logic                    in_access;

  assign req_start = wb_req_i.cyc && wb_req_i.stb;

  // Unsigned wrap makes each check a single compare
  assign l2_offs   = wb_req_i.adr - L2_BASE;
  assign mbox_offs = wb_req_i.adr - MBOX_BASE;
  assign cnt_offs  = wb_req_i.adr - CNT_BASE;

  always_comb begin
    region_d = REGION_NONE;
    offs_d   = '0;
    if (l2_offs < L2_WINDOW) begin
      region_d = REGION_L2;
      offs_d   = l2_offs;
    end else if (mbox_offs < REGION_SIZE) begin
      region_d = REGION_MBOX;
      offs_d   = mbox_offs;
    end else if (cnt_offs < REGION_SIZE) begin
      region_d = REGION_CNT;
      offs_d   = cnt_offs;
    end
  end

  always_comb begin
    case (state_q)
      IDLE:    state_d = req_start ? ACCESS : IDLE;
      ACCESS:  state_d = RESP;
      RESP:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Latched request fields
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_start) begin
      region_q <= region_d;
      woff_q   <= offs_d[WOFF_WIDTH+1:2];
      we_q     <= wb_req_i.we;
      dat_q    <= wb_req_i.dat;
      sel_q    <= wb_req_i.sel;
    end
  end

  assign in_access = (state_q == ACCESS);

  always_comb begin
    acc_req.valid    = 1'b0;
    acc_req.we       = we_q;
    acc_req.woff     = woff_q;
    acc_req.dat      = dat_q;
    acc_req.sel      = sel_q;
    l2_req_o         = acc_req;
    mbox_req_o       = acc_req;
    cnt_req_o        = acc_req;
    l2_req_o.valid   = in_access && (region_q == REGION_L2);
    mbox_req_o.valid = in_access && (region_q == REGION_MBOX);
    cnt_req_o.valid  = in_access && (region_q == REGION_CNT);
  end

  // Counter events
  assign l2_rd_o   = in_access && (region_q == REGION_L2) && !we_q;
  assign l2_wr_o   = in_access && (region_q == REGION_L2) && we_q;
  assign bus_err_o = in_access && (region_q == REGION_NONE);

  always_comb begin
    wb_rsp_o = '0;
    if (state_q == RESP) begin
      wb_rsp_o.ack = (region_q != REGION_NONE);
      wb_rsp_o.err = (region_q == REGION_NONE);
      case (region_q)
        REGION_L2:   wb_rsp_o.dat = l2_rdata_i;
        REGION_MBOX: wb_rsp_o.dat = mbox_rdata_i;
        REGION_CNT:  wb_rsp_o.dat = cnt_rdata_i;
        default:     wb_rsp_o.dat = '0;
      endcase
    end
  end

  // One of ack or err two edges after sampling, err only for an unmapped address
  a_rsp_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q == IDLE && req_start) |->
      ##2 ((wb_rsp_o.ack != wb_rsp_o.err) &&
           (wb_rsp_o.err == $past(region_d == REGION_NONE, 2))));

  a_rsp_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    (wb_rsp_o.ack || wb_rsp_o.err) |=> !(wb_rsp_o.ack || wb_rsp_o.err));

endmodule

// File: hw/l2_banked_mem.sv
// Word-interleaved banked L2 scratchpad with byte enables
`timescale 1ns/1ps

module l2_banked_mem
  import host_cfg_pkg::*;
  import host_bus_pkg::*;
#(
  parameter int unsigned NB_L2_BANKS  = 8,
  parameter int unsigned L2_BANK_SIZE = 2048
) (
  input  logic                  clk_i,
  input  tgt_req_t              req_i,
  output logic [DATA_WIDTH-1:0] rdata_o
);

  localparam int unsigned TOTAL_WORDS = NB_L2_BANKS * L2_BANK_SIZE;
  localparam int unsigned BANK_W = (NB_L2_BANKS > 1) ? $clog2(NB_L2_BANKS) : 1;
  localparam int unsigned ROW_W  = (L2_BANK_SIZE > 1) ? $clog2(L2_BANK_SIZE) : 1;

  logic [WOFF_WIDTH-1:0] word;
  logic [BANK_W-1:0]     bank, bank_q;
  logic [ROW_W-1:0]      row;
  logic [DATA_WIDTH-1:0] bank_rdata [NB_L2_BANKS];

  // Window aliases onto the physical words
  assign word = WOFF_WIDTH'(req_i.woff % TOTAL_WORDS);
  // Low bits select the bank, the rest the row
  assign bank = BANK_W'(word % NB_L2_BANKS);
  assign row  = ROW_W'(word / NB_L2_BANKS);

  for (genvar g = 0; g < NB_L2_BANKS; g++) begin : gen_bank
    logic [DATA_WIDTH-1:0] mem [L2_BANK_SIZE];
    logic [DATA_WIDTH-1:0] rdata_q;
    logic                  hit;

    assign hit = req_i.valid && (bank == BANK_W'(g));

    always_ff @(posedge clk_i) begin
      if (hit) begin
        if (req_i.we) begin
          for (int b = 0; b < SEL_WIDTH; b++) begin
            if (req_i.sel[b]) begin
              mem[row][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
          end
        end else begin
          rdata_q <= mem[row];
        end
      end
    end

    assign bank_rdata[g] = rdata_q;
  end

  // Remember which bank answers the read
  always_ff @(posedge clk_i) begin
    if (req_i.valid && !req_i.we) begin
      bank_q <= bank;
    end
  end

  assign rdata_o = bank_rdata[bank_q];

  a_bank_range: assert property (@(posedge clk_i)
    req_i.valid |-> (bank < NB_L2_BANKS));

endmodule

// File: hw/mailbox_regs.sv
// Doorbell and completion set/clear registers with their interrupts
`timescale 1ns/1ps

module mailbox_regs
  import host_cfg_pkg::*;
  import host_bus_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  tgt_req_t              req_i,
  output logic [DATA_WIDTH-1:0] rdata_o,
  output logic                  doorbell_irq_o,
  output logic                  completion_irq_o
);

  logic [3:0]            reg_off;
  logic [DATA_WIDTH-1:0] wmask, wdata;
  logic [DATA_WIDTH-1:0] doorbell_q, doorbell_d;
  logic [DATA_WIDTH-1:0] completion_q, completion_d;

  assign reg_off = {req_i.woff[1:0], 2'b00};

  always_comb begin
    for (int b = 0; b < SEL_WIDTH; b++) begin
      wmask[8*b +: 8] = {8{req_i.sel[b]}};
    end
  end

  // Unselected bytes neither set nor clear
  assign wdata = req_i.dat & wmask;

  always_comb begin
    doorbell_d   = doorbell_q;
    completion_d = completion_q;
    if (req_i.valid && req_i.we) begin
      case (reg_off)
        DOORBELL_SET:   doorbell_d   = doorbell_q | wdata;
        DOORBELL_CLR:   doorbell_d   = doorbell_q & ~wdata;
        COMPLETION_SET: completion_d = completion_q | wdata;
        COMPLETION_CLR: completion_d = completion_q & ~wdata;
        default:        ;
      endcase
    end
  end

  // Interrupts follow the new value, so they rise together with the write
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      doorbell_q       <= '0;
      completion_q     <= '0;
      doorbell_irq_o   <= 1'b0;
      completion_irq_o <= 1'b0;
    end else begin
      doorbell_q       <= doorbell_d;
      completion_q     <= completion_d;
      doorbell_irq_o   <= (doorbell_d != '0);
      completion_irq_o <= (completion_d != '0);
    end
  end

  assign rdata_o = (reg_off == COMPLETION_SET || reg_off == COMPLETION_CLR) ?
                   completion_q : doorbell_q;

endmodule

// File: hw/access_counters.sv
// L2 read, L2 write and bus error event counters
`timescale 1ns/1ps

module access_counters
  import host_cfg_pkg::*;
  import host_bus_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  l2_rd_i,
  input  logic                  l2_wr_i,
  input  logic                  bus_err_i,
  input  tgt_req_t              req_i,
  output logic [DATA_WIDTH-1:0] rdata_o
);

  logic [3:0]  reg_off;
  logic        clear;
  logic [31:0] read_cnt_q, write_cnt_q, error_cnt_q;

  assign reg_off = {req_i.woff[1:0], 2'b00};

  // Any write into the region wipes all three
  assign clear = req_i.valid && req_i.we;

  always_ff @(posedge clk_i) begin
    if (reset_i || clear) begin
      read_cnt_q  <= '0;
      write_cnt_q <= '0;
      error_cnt_q <= '0;
    end else begin
      // Counters wrap
      if (l2_rd_i) begin
        read_cnt_q <= read_cnt_q + 32'd1;
      end
      if (l2_wr_i) begin
        write_cnt_q <= write_cnt_q + 32'd1;
      end
      if (bus_err_i) begin
        error_cnt_q <= error_cnt_q + 32'd1;
      end
    end
  end

  always_comb begin
    case (reg_off)
      READ_CNT:  rdata_o = read_cnt_q;
      WRITE_CNT: rdata_o = write_cnt_q;
      ERROR_CNT: rdata_o = error_cnt_q;
      default:   rdata_o = '0;
    endcase
  end

endmodule

// File: hw/host_domain.sv
// Host domain top level with bus FSM, L2, mailbox and counters
`timescale 1ns/1ps

module host_domain
  import host_cfg_pkg::*;
  import host_bus_pkg::*;
#(
  parameter int unsigned NB_L2_BANKS  = 8,
  parameter int unsigned L2_BANK_SIZE = 2048
) (
  input  logic    clk_i,
  input  logic    reset_i,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o,
  output logic    doorbell_irq_o,
  output logic    completion_irq_o
);

  tgt_req_t              l2_req, mbox_req, cnt_req;
  logic [DATA_WIDTH-1:0] l2_rdata, mbox_rdata, cnt_rdata;
  logic                  l2_rd, l2_wr, bus_err;

  host_bus_fsm i_host_bus_fsm (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .wb_req_i     ( wb_req_i   ),
    .wb_rsp_o     ( wb_rsp_o   ),
    .l2_req_o     ( l2_req     ),
    .mbox_req_o   ( mbox_req   ),
    .cnt_req_o    ( cnt_req    ),
    .l2_rdata_i   ( l2_rdata   ),
    .mbox_rdata_i ( mbox_rdata ),
    .cnt_rdata_i  ( cnt_rdata  ),
    .l2_rd_o      ( l2_rd      ),
    .l2_wr_o      ( l2_wr      ),
    .bus_err_o    ( bus_err    )
  );

  l2_banked_mem #(
    .NB_L2_BANKS  ( NB_L2_BANKS  ),
    .L2_BANK_SIZE ( L2_BANK_SIZE )
  ) i_l2_banked_mem (
    .clk_i   ( clk_i    ),
    .req_i   ( l2_req   ),
    .rdata_o ( l2_rdata )
  );

  mailbox_regs i_mailbox_regs (
    .clk_i            ( clk_i            ),
    .reset_i          ( reset_i          ),
    .req_i            ( mbox_req         ),
    .rdata_o          ( mbox_rdata       ),
    .doorbell_irq_o   ( doorbell_irq_o   ),
    .completion_irq_o ( completion_irq_o )
  );

  access_counters i_access_counters (
    .clk_i     ( clk_i     ),
    .reset_i   ( reset_i   ),
    .l2_rd_i   ( l2_rd     ),
    .l2_wr_i   ( l2_wr     ),
    .bus_err_i ( bus_err   ),
    .req_i     ( cnt_req   ),
    .rdata_o   ( cnt_rdata )
  );

endmodule

// File: verif/host_domain_checker.sv
// Reference model of the host domain with response, timing and interrupt checks
`timescale 1ns/1ps

module host_domain_checker
  import host_cfg_pkg::*;
  import host_bus_pkg::*;
#(
  parameter int unsigned NB_L2_BANKS  = 8,
  parameter int unsigned L2_BANK_SIZE = 2048
) (
  input  logic    clk_i,
  input  logic    reset_i,
  input  wb_req_t wb_req_i,
  input  wb_rsp_t wb_rsp_i,
  input  logic    doorbell_irq_i,
  input  logic    completion_irq_i,
  output int      fail_count_o,
  output int      txn_count_o
);

  localparam int unsigned L2_WORDS = NB_L2_BANKS * L2_BANK_SIZE;

  logic [DATA_WIDTH-1:0] l2_data    [L2_WORDS];
  logic [SEL_WIDTH-1:0]  l2_written [L2_WORDS];
  logic [DATA_WIDTH-1:0] doorbell, completion;
  logic [31:0]           rd_cnt, wr_cnt, err_cnt;
  wb_req_t               req_q;
  logic                  busy;
  int                    edge_cnt;
  int                    fails = 0;
  int                    txns = 0;

  assign fail_count_o = fails;
  assign txn_count_o  = txns;

  function automatic logic [DATA_WIDTH-1:0] byte_mask(input logic [SEL_WIDTH-1:0] sel);
    logic [DATA_WIDTH-1:0] m;
    for (int b = 0; b < SEL_WIDTH; b++) begin
      m[8*b +: 8] = {8{sel[b]}};
    end
    return m;
  endfunction

  function automatic region_e region_of(input logic [ADDR_WIDTH-1:0] adr);
    if (adr >= L2_BASE && adr < L2_BASE + L2_WINDOW) begin
      return REGION_L2;
    end else if (adr >= MBOX_BASE && adr < MBOX_BASE + REGION_SIZE) begin
      return REGION_MBOX;
    end else if (adr >= CNT_BASE && adr < CNT_BASE + REGION_SIZE) begin
      return REGION_CNT;
    end
    return REGION_NONE;
  endfunction

  task automatic report(input string msg);
    $display("CHECK FAILED t=%0t: %s", $time, msg);
    fails++;
  endtask

  task automatic compare(input string what, input logic [DATA_WIDTH-1:0] got,
                         input logic [DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      report($sformatf("%s adr %h read %h, expected %h", what, req_q.adr, got, exp));
    end
  endtask

  // Response cycle of the latched request, then the model update
  task automatic finish_txn();
    region_e               r;
    logic [DATA_WIDTH-1:0] m, wm;
    logic [3:0]            off;
    int unsigned           w;
    r   = region_of(req_q.adr);
    off = {req_q.adr[3:2], 2'b00};
    m   = byte_mask(req_q.sel);
    txns++;
    if (r == REGION_NONE) begin
      if (!wb_rsp_i.err || wb_rsp_i.ack) begin
        report($sformatf("unmapped adr %h expected err only, ack=%b err=%b",
                         req_q.adr, wb_rsp_i.ack, wb_rsp_i.err));
      end
      err_cnt++;
      return;
    end
    if (!wb_rsp_i.ack || wb_rsp_i.err) begin
      report($sformatf("adr %h expected ack only, ack=%b err=%b",
                       req_q.adr, wb_rsp_i.ack, wb_rsp_i.err));
    end
    case (r)
      REGION_L2: begin
        w = ((req_q.adr - L2_BASE) >> 2) % L2_WORDS;
        if (req_q.we) begin
          l2_data[w]    = (l2_data[w] & ~m) | (req_q.dat & m);
          l2_written[w] = l2_written[w] | req_q.sel;
          wr_cnt++;
        end else begin
          // Bytes never written hold no defined value
          wm = byte_mask(l2_written[w]);
          compare("L2", wb_rsp_i.dat & wm, l2_data[w] & wm);
          rd_cnt++;
        end
      end
      REGION_MBOX: begin
        if (req_q.we) begin
          case (off)
            DOORBELL_SET:   doorbell   = doorbell | (req_q.dat & m);
            DOORBELL_CLR:   doorbell   = doorbell & ~(req_q.dat & m);
            COMPLETION_SET: completion = completion | (req_q.dat & m);
            default:        completion = completion & ~(req_q.dat & m);
          endcase
        end else begin
          compare("mailbox", wb_rsp_i.dat, off[3] ? completion : doorbell);
        end
      end
      default: begin
        if (req_q.we) begin
          rd_cnt  = '0;
          wr_cnt  = '0;
          err_cnt = '0;
        end else begin
          case (off)
            READ_CNT:  compare("read counter", wb_rsp_i.dat, rd_cnt);
            WRITE_CNT: compare("write counter", wb_rsp_i.dat, wr_cnt);
            ERROR_CNT: compare("error counter", wb_rsp_i.dat, err_cnt);
            default:   compare("counter offset 12", wb_rsp_i.dat, '0);
          endcase
        end
      end
    endcase
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      busy       = 1'b0;
      edge_cnt   = 0;
      doorbell   = '0;
      completion = '0;
      rd_cnt     = '0;
      wr_cnt     = '0;
      err_cnt    = '0;
      for (int i = 0; i < L2_WORDS; i++) begin
        l2_written[i] = '0;
      end
    end else begin
      if (busy) begin
        edge_cnt++;
        if (edge_cnt == 1) begin
          if (wb_rsp_i.ack || wb_rsp_i.err) begin
            report($sformatf("adr %h answered one cycle early", req_q.adr));
          end
        end else begin
          finish_txn();
          busy = 1'b0;
        end
      end else begin
        if (wb_rsp_i.ack || wb_rsp_i.err) begin
          report("ack or err high outside the response cycle");
        end
        if (wb_req_i.cyc && wb_req_i.stb) begin
          req_q    = wb_req_i;
          busy     = 1'b1;
          edge_cnt = 0;
        end
      end
      // Interrupts track the model from the response cycle on
      if (doorbell_irq_i !== (doorbell != '0)) begin
        report($sformatf("doorbell irq %b with register %h", doorbell_irq_i, doorbell));
      end
      if (completion_irq_i !== (completion != '0)) begin
        report($sformatf("completion irq %b with register %h", completion_irq_i, completion));
      end
    end
  end

endmodule

// File: verif/host_domain_tb.sv
// Host domain testbench with clock, reset, random Wishbone traffic and watchdog
`timescale 1ns/1ps

module host_domain_tb
  import host_cfg_pkg::*;
  import host_bus_pkg::*;
();

  // Small L2 so the 64 KiB window aliases
  localparam int unsigned NB_BANKS   = 4;
  localparam int unsigned BANK_SIZE  = 512;
  localparam int unsigned L2_BYTES   = NB_BANKS * BANK_SIZE * 4;
  localparam int unsigned CLK_PERIOD = 4;
  localparam int unsigned L2_WRITES  = 64;
  localparam int unsigned BANK_RUN   = 3 * NB_BANKS;
  localparam int unsigned MBOX_OPS   = 48;
  localparam int unsigned MIX_OPS    = 40;
  localparam int unsigned N_TESTS    = 5;
  localparam int unsigned TXN_TOTAL  = 3 * L2_WRITES + 2 * BANK_RUN + MBOX_OPS + 8 + 13 +
                                       MIX_OPS + 8;
  localparam int unsigned TIMEOUT_NS = (TXN_TOTAL * 8 + 100) * CLK_PERIOD;

  logic    clk = 1'b0;
  logic    reset;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  logic    doorbell_irq, completion_irq;
  int      fail_count, txn_checked;
  int      txn_issued = 0;
  int      tests_done = 0;
  int      txn_at_start, fail_at_start;

  always #(CLK_PERIOD / 2) clk = ~clk;

  host_domain #(
    .NB_L2_BANKS  ( NB_BANKS  ),
    .L2_BANK_SIZE ( BANK_SIZE )
  ) UUT (
    .clk_i            ( clk            ),
    .reset_i          ( reset          ),
    .wb_req_i         ( wb_req         ),
    .wb_rsp_o         ( wb_rsp         ),
    .doorbell_irq_o   ( doorbell_irq   ),
    .completion_irq_o ( completion_irq )
  );

  host_domain_checker #(
    .NB_L2_BANKS  ( NB_BANKS  ),
    .L2_BANK_SIZE ( BANK_SIZE )
  ) i_checker (
    .clk_i            ( clk            ),
    .reset_i          ( reset          ),
    .wb_req_i         ( wb_req         ),
    .wb_rsp_i         ( wb_rsp         ),
    .doorbell_irq_i   ( doorbell_irq   ),
    .completion_irq_i ( completion_irq ),
    .fail_count_o     ( fail_count     ),
    .txn_count_o      ( txn_checked    )
  );

  // One classic cycle, held until ack or err
  task automatic bus_xfer(input logic [31:0] adr, input logic we, input logic [31:0] dat,
                          input logic [3:0] sel);
    repeat ($urandom_range(0, 2)) @(negedge clk);
    @(negedge clk);
    wb_req.adr = adr;
    wb_req.we  = we;
    wb_req.dat = dat;
    wb_req.sel = sel;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    do @(negedge clk); while (!(wb_rsp.ack || wb_rsp.err));
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
    txn_issued++;
  endtask

  task automatic start_test();
    txn_at_start  = txn_issued;
    fail_at_start = fail_count;
  endtask

  task automatic end_test(input string name);
    @(negedge clk);
    tests_done++;
    $display("Test %-10s done: %0d transactions, %0d check failures", name,
             txn_issued - txn_at_start, fail_count - fail_at_start);
  endtask

  task automatic test_l2_random();
    logic [31:0] adrs [$];
    logic [31:0] adr;
    start_test();
    for (int i = 0; i < L2_WRITES; i++) begin
      adr = L2_BASE + ($urandom_range(0, L2_WINDOW / 4 - 1) << 2);
      adrs.push_back(adr);
      bus_xfer(adr, 1'b1, $urandom, 4'($urandom_range(1, 15)));
    end
    foreach (adrs[i]) begin
      bus_xfer(adrs[i], 1'b0, '0, 4'hf);
    end
    // Same words through another alias of the window
    foreach (adrs[i]) begin
      adr = L2_BASE + ((adrs[i] - L2_BASE +
                        L2_BYTES * $urandom_range(1, L2_WINDOW / L2_BYTES - 1)) % L2_WINDOW);
      bus_xfer(adr, 1'b0, '0, 4'hf);
    end
    end_test("l2_random");
  endtask

  task automatic test_l2_banks();
    logic [31:0] base;
    start_test();
    base = L2_BASE + ($urandom_range(0, L2_WINDOW / 4 - BANK_RUN) << 2);
    for (int i = 0; i < BANK_RUN; i++) begin
      bus_xfer(base + 4 * i, 1'b1, {16'hba00 + 16'(i), 16'($urandom)}, 4'hf);
    end
    for (int i = 0; i < BANK_RUN; i++) begin
      bus_xfer(base + 4 * i, 1'b0, '0, 4'hf);
    end
    end_test("l2_banks");
  endtask

  task automatic test_mailbox();
    logic [31:0] adr;
    logic [31:0] dat;
    start_test();
    for (int i = 0; i < MBOX_OPS; i++) begin
      adr = MBOX_BASE + ($urandom_range(0, 3) << 2);
      dat = ($urandom_range(0, 3) == 0) ? 32'hffff_ffff : $urandom;
      bus_xfer(adr, $urandom_range(0, 3) != 0, dat, 4'($urandom_range(0, 15)));
    end
    // Full clear drops both interrupts
    bus_xfer(MBOX_BASE + DOORBELL_CLR, 1'b1, 32'hffff_ffff, 4'hf);
    bus_xfer(MBOX_BASE + COMPLETION_CLR, 1'b1, 32'hffff_ffff, 4'hf);
    bus_xfer(MBOX_BASE + DOORBELL_SET, 1'b1, 32'h0000_0100, 4'h2);
    bus_xfer(MBOX_BASE + COMPLETION_SET, 1'b1, 32'h8000_0000, 4'h8);
    for (int off = 0; off < 16; off += 4) begin
      bus_xfer(MBOX_BASE + off, 1'b0, '0, 4'hf);
    end
    end_test("mailbox");
  endtask

  task automatic test_unmapped();
    logic [31:0] bad [6];
    start_test();
    bad[0] = MBOX_BASE + REGION_SIZE;
    bad[1] = CNT_BASE + REGION_SIZE;
    bad[2] = 32'h0003_0000;
    bad[3] = 32'h8000_0000;
    bad[4] = 32'hffff_fffc;
    bad[5] = 32'h0003_0000 + ($urandom_range(0, 32'h0fff_ffff) << 2);
    foreach (bad[i]) begin
      bus_xfer(bad[i], 1'b0, '0, 4'hf);
      bus_xfer(bad[i], 1'b1, $urandom, 4'hf);
    end
    bus_xfer(CNT_BASE + 12, 1'b0, '0, 4'hf);
    end_test("unmapped");
  endtask

  task automatic test_counters();
    logic [31:0] adr;
    start_test();
    bus_xfer(CNT_BASE, 1'b1, '0, 4'hf);
    for (int i = 0; i < MIX_OPS; i++) begin
      adr = L2_BASE + ($urandom_range(0, L2_WINDOW / 4 - 1) << 2);
      case ($urandom_range(0, 2))
        0:       bus_xfer(adr, 1'b0, '0, 4'hf);
        1:       bus_xfer(adr, 1'b1, $urandom, 4'($urandom_range(1, 15)));
        default: bus_xfer(32'h0004_0000 + adr, $urandom_range(0, 1), $urandom, 4'hf);
      endcase
    end
    for (int off = 0; off < 12; off += 4) begin
      bus_xfer(CNT_BASE + off, 1'b0, '0, 4'hf);
    end
    bus_xfer(CNT_BASE + WRITE_CNT, 1'b1, $urandom, 4'hf);
    for (int off = 0; off < 12; off += 4) begin
      bus_xfer(CNT_BASE + off, 1'b0, '0, 4'hf);
    end
    end_test("counters");
  endtask

  initial begin
    void'($urandom(46));
    reset  = 1'b1;
    wb_req = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    test_l2_random();
    test_l2_banks();
    test_mailbox();
    test_unmapped();
    test_counters();
    repeat (4) @(negedge clk);
    if (txn_checked != txn_issued) begin
      $display("Checker saw %0d transactions but %0d were issued", txn_checked, txn_issued);
    end
    $display("Summary: %0d of %0d tests run, %0d transactions, %0d check failures",
             tests_done, N_TESTS, txn_issued, fail_count);
    if (fail_count == 0 && txn_checked == txn_issued) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: all.f
hw/host_cfg_pkg.sv
hw/host_bus_pkg.sv
hw/host_bus_fsm.sv
hw/l2_banked_mem.sv
hw/mailbox_regs.sv
hw/access_counters.sv
hw/host_domain.sv
verif/host_domain_checker.sv
verif/host_domain_tb.sv

// File: Bender.yml
package:
  name: host_domain

sources:
  - files:
      - hw/host_cfg_pkg.sv
      - hw/host_bus_pkg.sv
      - hw/host_bus_fsm.sv
      - hw/l2_banked_mem.sv
      - hw/mailbox_regs.sv
      - hw/access_counters.sv
      - hw/host_domain.sv
  - target: test
    files:
      - verif/host_domain_checker.sv
      - verif/host_domain_tb.sv
